//--- Bender.yml
package:
  name: vdisk_bridge

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vdisk_pkg.sv
      - rtl/host_pkg.sv
      - rtl/vdisk_status_if.sv
      - rtl/mount_status.sv
      - rtl/req_watchdog.sv
      - rtl/vdisk_fsm.sv
      - rtl/sector_buffer.sv
      - rtl/vdisk_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/host_disk_model.sv
      - tests/tb_vdisk_top.sv

//--- rtl/host_pkg.sv
`default_nettype none

`include "vdisk_settings.svh"

package host_pkg;

	// Sector number as seen by the host
	typedef logic [`VDISK_LBA_W-1:0] lba_t;

	// One bit wider than lba_t so a full image still fits
	typedef logic [`VDISK_LBA_W:0] sector_count_t;

endpackage

`default_nettype wire

//--- rtl/mount_status.sv
`default_nettype none

`include "vdisk_settings.svh"

module mount_status import host_pkg::*; (
	input  wire          clk_sys,
	input  wire          reset,
	input  wire          img_mounted,
	input  wire          img_readonly,
	input  wire [63:0]   img_size,
	vdisk_status_if.source status
);

	localparam int cnt_w = $bits(sector_count_t);
	localparam int whole_w = 64 - `VDISK_BUF_AW;

	logic [whole_w-1:0] whole_sectors;
	sector_count_t      size_count;

	// Bytes to sectors, a partial last sector is not usable
	assign whole_sectors = img_size[63:`VDISK_BUF_AW];

	// Clamp anything larger than the count range
	assign size_count = (|whole_sectors[whole_w-1:cnt_w]) ? '1 : whole_sectors[cnt_w-1:0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status.mounted       <= 1'b0;
			status.read_only     <= 1'b0;
			status.sector_count  <= '0;
			status.media_changed <= 1'b0;
		end else begin
			status.media_changed <= img_mounted;
			if (img_mounted) begin
				status.mounted      <= (img_size != 64'd0); // Size 0 means eject
				status.read_only    <= img_readonly;
				status.sector_count <= size_count;
			end
		end
	end

	a_no_count_unmounted: assert property (
		@(posedge clk_sys) disable iff (reset)
		!status.mounted |-> (status.sector_count == '0)
	);

endmodule

`default_nettype wire

//--- rtl/req_watchdog.sv
`default_nettype none

`include "vdisk_settings.svh"

module req_watchdog (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  run,
	output logic expired
);

	localparam int cnt_w = $clog2(`VDISK_WATCHDOG_CYCLES + 1);
	localparam logic [cnt_w-1:0] limit = cnt_w'(`VDISK_WATCHDOG_CYCLES);

	logic [cnt_w-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (reset || !run)
			count <= '0;
		else if (count != limit)
			count <= count + 1'b1; // Holds at the limit
	end

	assign expired = run && (count == limit);

	// Expiry needs run held over the whole count window
	a_expire_needs_run: assert property (
		@(posedge clk_sys) disable iff (reset)
		$rose(expired) |-> run && $past(run, `VDISK_WATCHDOG_CYCLES)
	);

endmodule

`default_nettype wire

//--- rtl/sector_buffer.sv
`default_nettype none

`include "vdisk_settings.svh"

module sector_buffer (
	input  wire                     clk_sys,
	input  wire [`VDISK_BUF_AW-1:0] buf_addr,
	input  wire [7:0]               buf_wdata,
	input  wire                     buf_we,
	output logic [7:0]              buf_rdata,
	input  wire [`VDISK_BUF_AW-1:0] sd_buff_addr,
	input  wire [7:0]               sd_buff_dout,
	input  wire                     sd_buff_wr,
	input  wire                     sd_ack,
	output logic [7:0]              sd_buff_din
);

	logic [7:0] mem [`VDISK_SECTOR_BYTES];
	logic       host_we;

	// Host strobes outside a transfer are ignored
	assign host_we = sd_buff_wr & sd_ack;

	// Controller port
	always @(posedge clk_sys) begin
		if (buf_we)
			mem[buf_addr] <= buf_wdata;
		buf_rdata <= mem[buf_addr]; // Old data on same-address write
	end

	// Host port
	always @(posedge clk_sys) begin
		if (host_we)
			mem[sd_buff_addr] <= sd_buff_dout;
		sd_buff_din <= mem[sd_buff_addr];
	end

endmodule

`default_nettype wire

//--- rtl/vdisk_fsm.sv
`default_nettype none

module vdisk_fsm import vdisk_pkg::*, host_pkg::*; (
	input  wire           clk_sys,
	input  wire           reset,
	input  wire           disk_req,
	input  wire disk_op_e disk_op,
	input  wire lba_t     disk_lba,
	output logic          disk_ack,
	output disk_status_e  disk_status,
	output logic          sd_rd,
	output logic          sd_wr,
	output lba_t          sd_lba,
	input  wire           sd_ack,
	vdisk_status_if.sink  status,
	output logic          wd_run,
	input  wire           wd_expired
);

	typedef enum logic [2:0] {
		s_idle,
		s_check,
		s_host_req,
		s_host_xfer,
		s_done
	} state_t;

	state_t        state;
	disk_op_e      op_q;
	logic          sd_ack_q;
	logic          ack_rise;
	logic          ack_fall;
	logic          mnt_ok;
	logic          mnt_ro;
	sector_count_t mnt_count;
	disk_status_e  check_status;

	// Mount state as of the last mount event
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mnt_ok    <= 1'b0;
			mnt_ro    <= 1'b0;
			mnt_count <= '0;
		end else if (status.media_changed) begin
			mnt_ok    <= status.mounted;
			mnt_ro    <= status.read_only;
			mnt_count <= status.sector_count;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			sd_ack_q <= 1'b0;
		else
			sd_ack_q <= sd_ack;
	end

	assign ack_rise = sd_ack & ~sd_ack_q;
	assign ack_fall = ~sd_ack & sd_ack_q;

	assign wd_run = (state == s_host_req); // Only waiting on the host is timed

	// Request captured once, controller keeps it stable anyway
	always_ff @(posedge clk_sys) begin
		if (state == s_idle && disk_req) begin
			op_q   <= disk_op;
			sd_lba <= disk_lba;
		end
	end

	always_comb begin
		check_status = st_ok;
		if (!mnt_ok)
			check_status = st_no_media;
		else if (op_q == op_write && mnt_ro)
			check_status = st_protected;
		else if (sector_count_t'(sd_lba) >= mnt_count)
			check_status = st_out_of_range;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= s_idle;
			disk_ack    <= 1'b0;
			disk_status <= st_ok;
			sd_rd       <= 1'b0;
			sd_wr       <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					if (disk_req)
						state <= s_check;
				end
				s_check: begin
					if (check_status != st_ok) begin
						disk_ack    <= 1'b1; // Rejected, host never sees it
						disk_status <= check_status;
						state       <= s_done;
					end else begin
						sd_rd <= (op_q == op_read);
						sd_wr <= (op_q == op_write);
						state <= s_host_req;
					end
				end
				s_host_req: begin
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= s_host_xfer;
					end else if (wd_expired) begin
						sd_rd       <= 1'b0;
						sd_wr       <= 1'b0;
						disk_ack    <= 1'b1;
						disk_status <= st_timeout;
						state       <= s_done;
					end
				end
				s_host_xfer: begin
					// Host drops sd_ack once the buffer is done
					if (ack_fall) begin
						disk_ack    <= 1'b1;
						disk_status <= st_ok;
						state       <= s_done;
					end
				end
				s_done: begin
					if (!disk_req) begin
						disk_ack <= 1'b0;
						state    <= s_idle;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	a_one_host_op: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr)
	);

	// Four-phase rule, ack may only drop after req has gone
	a_ack_held: assert property (
		@(posedge clk_sys) disable iff (reset)
		disk_ack && disk_req |=> disk_ack
	);

endmodule

`default_nettype wire

//--- rtl/vdisk_pkg.sv
`default_nettype none

package vdisk_pkg;

	// Operation requested by the emulated controller
	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} disk_op_e;

	// Result returned with disk_ack
	typedef enum logic [2:0] {
		st_ok           = 3'd0,
		st_no_media     = 3'd1,
		st_protected    = 3'd2, // Write to a read-only image
		st_out_of_range = 3'd3,
		st_timeout      = 3'd4  // Host never answered
	} disk_status_e;

endpackage

`default_nettype wire

//--- rtl/vdisk_settings.svh
`ifndef VDISK_SETTINGS_SVH
`define VDISK_SETTINGS_SVH

// Sector geometry, one sector per transfer
`define VDISK_SECTOR_BYTES 512
`define VDISK_BUF_AW 9

// Emulated controller addresses up to 64K sectors
`define VDISK_LBA_W 16

// Cycles a host request may wait for sd_ack to rise
`define VDISK_WATCHDOG_CYCLES 4096

`endif

//--- rtl/vdisk_status_if.sv
`default_nettype none

interface vdisk_status_if import host_pkg::*; ();

	logic          mounted;
	logic          read_only;
	sector_count_t sector_count;  // Whole sectors in the image
	logic          media_changed; // One cycle per mount event

	modport source (
		output mounted,
		output read_only,
		output sector_count,
		output media_changed
	);

	modport sink (
		input mounted,
		input read_only,
		input sector_count,
		input media_changed
	);

endinterface

`default_nettype wire

//--- rtl/vdisk_top.sv
`default_nettype none

`include "vdisk_settings.svh"

module vdisk_top import vdisk_pkg::*, host_pkg::*; (
	input  wire                     clk_sys,
	input  wire                     reset,

	input  wire                     disk_req,
	input  wire disk_op_e           disk_op,
	input  wire lba_t               disk_lba,
	output logic                    disk_ack,
	output disk_status_e            disk_status,
	input  wire [`VDISK_BUF_AW-1:0] buf_addr,
	input  wire [7:0]               buf_wdata,
	input  wire                     buf_we,
	output logic [7:0]              buf_rdata,

	output logic                    sd_rd,
	output logic                    sd_wr,
	output lba_t                    sd_lba,
	input  wire                     sd_ack,
	input  wire [`VDISK_BUF_AW-1:0] sd_buff_addr,
	input  wire [7:0]               sd_buff_dout,
	input  wire                     sd_buff_wr,
	output logic [7:0]              sd_buff_din,

	input  wire                     img_mounted,
	input  wire                     img_readonly,
	input  wire [63:0]              img_size
);

	logic wd_run;
	logic wd_expired;

	vdisk_status_if mount_if ();

	mount_status i_mount_status (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.status       (mount_if.source)
	);

	req_watchdog i_req_watchdog (
		.clk_sys (clk_sys),
		.reset   (reset),
		.run     (wd_run),
		.expired (wd_expired)
	);

	vdisk_fsm i_vdisk_fsm (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.disk_req    (disk_req),
		.disk_op     (disk_op),
		.disk_lba    (disk_lba),
		.disk_ack    (disk_ack),
		.disk_status (disk_status),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.sd_lba      (sd_lba),
		.sd_ack      (sd_ack),
		.status      (mount_if.sink),
		.wd_run      (wd_run),
		.wd_expired  (wd_expired)
	);

	sector_buffer i_sector_buffer (
		.clk_sys      (clk_sys),
		.buf_addr     (buf_addr),
		.buf_wdata    (buf_wdata),
		.buf_we       (buf_we),
		.buf_rdata    (buf_rdata),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_ack       (sd_ack),
		.sd_buff_din  (sd_buff_din)
	);

endmodule

`default_nettype wire

//--- tests/host_disk_model.sv
`default_nettype none

`include "vdisk_settings.svh"

module host_disk_model import host_pkg::*; (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      sd_rd,
	input  wire                      sd_wr,
	input  wire lba_t                sd_lba,
	output logic                     sd_ack,
	output logic [`VDISK_BUF_AW-1:0] sd_buff_addr,
	output logic [7:0]               sd_buff_dout,
	output logic                     sd_buff_wr,
	input  wire [7:0]                sd_buff_din,
	input  wire                      silent
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int sector = `VDISK_SECTOR_BYTES;

	logic [7:0] image [64 * sector]; // Loaded by the testbench

	initial begin
		int   base;
		logic is_read;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (!reset && !silent && (sd_rd || sd_wr)) begin
				base    = int'(sd_lba[5:0]) * sector;
				is_read = sd_rd;
				repeat ($urandom_range(1, 20)) @(posedge clk_sys);
				sd_ack <= 1'b1;
				if (is_read) begin
					for (int i = 0; i < sector; i++) begin
						if (i > 0)
							@(posedge clk_sys);
						sd_buff_wr   <= 1'b1;
						sd_buff_addr <= `VDISK_BUF_AW'(i);
						sd_buff_dout <= image[base + i];
					end
				end else begin
					// Registered read port, data trails the address by two edges
					for (int j = 0; j < sector + 2; j++) begin
						if (j > 0)
							@(posedge clk_sys);
						if (j < sector)
							sd_buff_addr <= `VDISK_BUF_AW'(j);
						if (j >= 2)
							image[base + j - 2] = sd_buff_din;
					end
				end
				@(posedge clk_sys);
				sd_buff_wr <= 1'b0;
				sd_ack     <= 1'b0; // End of transfer
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_vdisk_top.sv
`default_nettype none

`include "vdisk_settings.svh"

module tb_vdisk_top import vdisk_pkg::*, host_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_req = 36;
	localparam int sector = `VDISK_SECTOR_BYTES;
	localparam int img_bytes = 64 * sector;
	localparam int run_limit = n_req * (`VDISK_WATCHDOG_CYCLES + 2000) * 40;

	logic clk_sys = 1'b0;
	logic reset;
	logic disk_req;
	disk_op_e disk_op;
	lba_t disk_lba;
	logic disk_ack;
	disk_status_e disk_status;
	logic [`VDISK_BUF_AW-1:0] buf_addr;
	logic [7:0] buf_wdata;
	logic buf_we;
	logic [7:0] buf_rdata;
	logic sd_rd;
	logic sd_wr;
	lba_t sd_lba;
	logic sd_ack;
	logic [`VDISK_BUF_AW-1:0] sd_buff_addr;
	logic [7:0] sd_buff_dout;
	logic sd_buff_wr;
	logic [7:0] sd_buff_din;
	logic img_mounted;
	logic img_readonly;
	logic [63:0] img_size;
	logic silent;

	logic [7:0] model_img [img_bytes];
	logic [7:0] wr_data [sector]; // Last pattern written into the buffer
	logic m_mounted;
	logic m_ro;
	int m_count;
	lba_t req_lba;  // Sector of the request in flight
	logic host_due; // Request is expected to reach the host

	vdisk_top i_vdisk_top (.*);
	host_disk_model i_host_disk_model (.*);

	always #20 clk_sys = ~clk_sys;

	task automatic compare_values(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at first error");
		end
	endtask

	function automatic logic [7:0] fill_byte(input int a);
		return a[7:0] ^ a[14:7] ^ 8'h5a;
	endfunction

	function automatic disk_status_e predict_status(input disk_op_e op, input int lba);
		if (!m_mounted)
			return st_no_media;
		if (op == op_write && m_ro)
			return st_protected;
		if (lba >= m_count)
			return st_out_of_range;
		return st_ok;
	endfunction

	task automatic mount_image(input logic [63:0] size, input logic ro);
		@(posedge clk_sys);
		img_mounted  <= 1'b1;
		img_size     <= size;
		img_readonly <= ro;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		repeat (3) @(posedge clk_sys); // Let the FSM pick up the new state
		m_mounted = (size != 0);
		m_ro      = ro;
		m_count   = ((size >> 9) > 64'd131071) ? 131071 : int'(size >> 9);
	endtask

	task automatic fill_buffer();
		for (int i = 0; i < sector; i++) begin
			@(posedge clk_sys);
			wr_data[i] = 8'($urandom);
			buf_we    <= 1'b1;
			buf_addr  <= `VDISK_BUF_AW'(i);
			buf_wdata <= wr_data[i];
		end
		@(posedge clk_sys);
		buf_we <= 1'b0;
	endtask

	task automatic check_readback(input string name, input int base);
		for (int j = 0; j < sector + 2; j++) begin
			@(posedge clk_sys);
			if (j < sector)
				buf_addr <= `VDISK_BUF_AW'(j);
			if (j >= 2)
				compare_values({name, " readback"}, model_img[base + j - 2], buf_rdata);
		end
	endtask

	task automatic compare_sector(input string name, input int base);
		for (int i = 0; i < sector; i++)
			compare_values({name, " host image"}, model_img[base + i],
				i_host_disk_model.image[base + i]);
	endtask

	task automatic run_request(input string name, input disk_op_e op, input lba_t lba,
			input int hold, output disk_status_e got);
		@(posedge clk_sys);
		disk_req <= 1'b1;
		disk_op  <= op;
		disk_lba <= lba;
		do @(posedge clk_sys); while (!disk_ack);
		got = disk_status;
		// Controller stalls while ack and status hold
		repeat (hold) begin
			@(posedge clk_sys);
			compare_values({name, " ack held"}, 1, disk_ack);
			compare_values({name, " status held"}, got, disk_status);
		end
		disk_req <= 1'b0;
		do @(posedge clk_sys); while (disk_ack);
	endtask

	// Host sees only accepted requests, with the requested sector
	always @(posedge clk_sys) begin
		if (!reset && (sd_rd || sd_wr)) begin
			compare_values("host req allowed", 1, host_due);
			compare_values("host lba", req_lba, sd_lba);
		end
	end

	initial begin
		#(run_limit);
		$display("Watchdog expired, the requests did not finish in time");
		$display("*** TEST FAILED ***");
		$fatal(1, "timeout");
	end

	initial begin
		disk_status_e expected;
		disk_status_e got;
		disk_op_e op;
		lba_t lba;
		int scenario;
		int count;
		int hold;
		logic [63:0] size;
		logic ro;
		string name;
		reset        = 1'b1;
		disk_req     = 1'b0;
		disk_op      = op_read;
		disk_lba     = '0;
		buf_addr     = '0;
		buf_wdata    = '0;
		buf_we       = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		silent       = 1'b0;
		req_lba      = '0;
		host_due     = 1'b0;
		void'($urandom(32'h609b));
		for (int a = 0; a < img_bytes; a++) begin
			model_img[a] = fill_byte(a);
			i_host_disk_model.image[a] = fill_byte(a);
		end
		m_mounted = 1'b0;
		m_ro      = 1'b0;
		m_count   = 0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);
		compare_values("reset ack", 0, disk_ack);
		compare_values("reset status", st_ok, disk_status);
		compare_values("reset host req", 0, {sd_rd, sd_wr});

		for (int n = 0; n < n_req; n++) begin
			name     = $sformatf("req %0d", n);
			scenario = $urandom_range(0, 5); // read, write, protected, eject, range, silent
			count    = $urandom_range(1, 64);
			size     = 64'(count) * sector;
			if ($urandom_range(0, 1) == 1)
				size += $urandom_range(1, sector - 1); // Partial tail sector
			if (scenario == 3)
				size = '0;
			ro = (scenario == 2) || (scenario == 0 && $urandom_range(0, 1) == 1);
			if (scenario == 1 || scenario == 2)
				op = op_write;
			else if (scenario == 0)
				op = op_read;
			else
				op = disk_op_e'($urandom_range(0, 1));
			if (scenario == 4)
				lba = lba_t'(count + $urandom_range(0, 100));
			else if (scenario == 3)
				lba = lba_t'($urandom_range(0, 100));
			else
				lba = lba_t'($urandom_range(0, count - 1));
			mount_image(size, ro);
			if (op == op_write)
				fill_buffer();
			expected = predict_status(op, int'(lba));
			if (scenario == 5 && expected == st_ok)
				expected = st_timeout;
			req_lba  = lba;
			host_due = (expected == st_ok) || (expected == st_timeout);
			hold = ($urandom_range(0, 2) == 0) ? $urandom_range(5, 40) : 0;
			silent <= (scenario == 5);
			run_request(name, op, lba, hold, got);
			silent <= 1'b0;
			compare_values({name, " status"}, expected, got);
			if (got == st_timeout) begin
				@(posedge clk_sys);
				compare_values({name, " host req after timeout"}, 0, {sd_rd, sd_wr});
			end
			if (op == op_read && got == st_ok) begin
				check_readback(name, int'(lba) * sector);
			end else if (op == op_write) begin
				if (got == st_ok)
					for (int i = 0; i < sector; i++)
						model_img[int'(lba) * sector + i] = wr_data[i];
				if (lba < 64)
					compare_sector(name, int'(lba) * sector);
			end
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- vdisk_top.f
+incdir+rtl
rtl/vdisk_pkg.sv
rtl/host_pkg.sv
rtl/vdisk_status_if.sv
rtl/mount_status.sv
rtl/req_watchdog.sv
rtl/vdisk_fsm.sv
rtl/sector_buffer.sv
rtl/vdisk_top.sv
tests/host_disk_model.sv
tests/tb_vdisk_top.sv
